/* Makefile */
# Verilator build and run of the ALU testbench

VERILATOR ?= verilator
TOP ?= tb_alu
LOG ?= sim.log
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR"

test:
	$(VERILATOR) --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* adder_subtractor.sv */
/*
 * Adder/subtractor
 * one 17-bit adder shared by the byte and pair add and subtract forms,
 * subtract done as a plus inverted b plus carry in
 */
`timescale 1ns/1ps
`default_nettype none

module adder_subtractor
(
	input wire pkg_alu::addsub_oper oper,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_lo,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_lo,
	input wire logic carry_in,
	output logic [pkg_alu::alu_inout_width-1:0] out_hi,
	output logic [pkg_alu::alu_inout_width-1:0] out_lo,
	output logic carry_out
);
	import pkg_alu::*;

	// keeps only the low byte on byte forms
	localparam logic [alu_inout_pair_width-1:0] byte_mask =
		{{alu_inout_width{1'b0}}, {alu_inout_width{1'b1}}};

	logic [alu_inout_pair_width-1:0] b_ext;
	logic [alu_inout_pair_width-1:0] a_opnd;
	logic [alu_inout_pair_width-1:0] b_opnd;
	logic [alu_inout_pair_width:0] sum;
	logic is_pair;
	logic is_sub;
	logic cin;

	// operand forming per operation
	always_comb
	begin
		b_ext = {b_in_hi, b_in_lo};
		is_pair = 1'b1;
		is_sub = 1'b0;
		cin = 1'b0;
		case (oper)
			addsub_op_add:
			begin
				is_pair = 1'b0;
			end
			addsub_op_adc:
			begin
				is_pair = 1'b0;
				cin = carry_in;
			end
			addsub_op_addpb:
			begin
				// byte operand zero extended
				b_ext = {{alu_inout_width{1'b0}}, b_in_lo};
			end
			addsub_op_addp:
			begin
				b_ext = {b_in_hi, b_in_lo};
			end
			addsub_op_addpsnx:
			begin
				// sign extended from bit 7
				b_ext = {{alu_inout_width{b_in_lo[alu_inout_width-1]}}, b_in_lo};
			end
			addsub_op_sub:
			begin
				is_pair = 1'b0;
				is_sub = 1'b1;
				cin = 1'b1;
			end
			addsub_op_sbc:
			begin
				// carry flag stands in for the +1
				is_pair = 1'b0;
				is_sub = 1'b1;
				cin = carry_in;
			end
			addsub_op_subpb:
			begin
				b_ext = {{alu_inout_width{1'b0}}, b_in_lo};
				is_sub = 1'b1;
				cin = 1'b1;
			end
			addsub_op_subp:
			begin
				is_sub = 1'b1;
				cin = 1'b1;
			end
			default:
			begin
				b_ext = '0;
			end
		endcase
	end

	// byte forms clear the high halves so sum[8] is the byte carry
	assign a_opnd = is_pair ? {a_in_hi, a_in_lo} : ({a_in_hi, a_in_lo} & byte_mask);
	assign b_opnd = is_pair ? (is_sub ? ~b_ext : b_ext) : ((is_sub ? ~b_ext : b_ext) & byte_mask);
	assign sum = {1'b0, a_opnd} + {1'b0, b_opnd} + {{alu_inout_pair_width{1'b0}}, cin};

	assign out_lo = sum[alu_inout_width-1:0];
	// high byte echoes a on byte forms
	assign out_hi = is_pair ? sum[alu_inout_pair_width-1:alu_inout_width] : a_in_hi;
	assign carry_out = is_pair ? sum[alu_inout_pair_width] : sum[alu_inout_width];

endmodule

`default_nettype wire

/* alu.sv */
/*
 * ALU top level
 * combinational datapath followed by one output register stage,
 * result and flags valid one cycle after the inputs
 */
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input wire logic clk,
	input wire logic rst,
	input wire pkg_alu::alu_oper oper,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_lo,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_lo,
	input wire logic [pkg_pflags::proc_flags_width-1:0] proc_flags_in,
	output logic [pkg_alu::alu_inout_width-1:0] out_hi,
	output logic [pkg_alu::alu_inout_width-1:0] out_lo,
	output logic [pkg_pflags::proc_flags_width-1:0] proc_flags_out
);
	import pkg_alu::*;
	import pkg_pflags::*;

	logic [alu_inout_width-1:0] next_hi;
	logic [alu_inout_width-1:0] next_lo;
	logic [proc_flags_width-1:0] next_flags;

	alu_datapath datapath_inst
	(
		.oper(oper),
		.a_in_hi(a_in_hi),
		.a_in_lo(a_in_lo),
		.b_in_hi(b_in_hi),
		.b_in_lo(b_in_lo),
		.proc_flags_in(proc_flags_in),
		.next_hi(next_hi),
		.next_lo(next_lo),
		.next_flags(next_flags)
	);

	// loads every edge, no enable
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_hi <= '0;
			out_lo <= '0;
			proc_flags_out <= '0;
		end
		else
		begin
			out_hi <= next_hi;
			out_lo <= next_lo;
			proc_flags_out <= next_flags;
		end
	end

endmodule

`default_nettype wire

/* alu_bitwise.sv */
/*
 * Bitwise unit
 * gate operations, byte and pair invert and negate; flags untouched
 */
`timescale 1ns/1ps
`default_nettype none

module alu_bitwise
(
	input wire pkg_alu::alu_oper oper,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_lo,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_lo,
	output logic [pkg_alu::alu_inout_width-1:0] out_hi,
	output logic [pkg_alu::alu_inout_width-1:0] out_lo
);
	import pkg_alu::*;

	logic [alu_inout_pair_width-1:0] a_pair;
	logic [alu_inout_pair_width-1:0] inv_pair;
	logic [alu_inout_pair_width-1:0] neg_pair;

	assign a_pair = {a_in_hi, a_in_lo};
	assign inv_pair = ~a_pair;
	// two's complement of the pair
	assign neg_pair = inv_pair + 1'b1;

	always_comb
	begin
		// byte ops leave the high byte as is
		out_hi = a_in_hi;
		out_lo = a_in_lo;
		case (oper)
			alu_op_and:
			begin
				out_lo = a_in_lo & b_in_lo;
			end
			alu_op_orr:
			begin
				out_lo = a_in_lo | b_in_lo;
			end
			alu_op_xor:
			begin
				out_lo = a_in_lo ^ b_in_lo;
			end
			alu_op_inv:
			begin
				out_lo = inv_pair[alu_inout_width-1:0];
			end
			alu_op_neg:
			begin
				out_lo = ~a_in_lo + 1'b1;
			end
			alu_op_invp:
			begin
				{out_hi, out_lo} = inv_pair;
			end
			alu_op_negp:
			begin
				{out_hi, out_lo} = neg_pair;
			end
			default:
			begin
				out_lo = a_in_lo;
			end
		endcase
	end

endmodule

`default_nettype wire

/* alu_datapath.sv */
/*
 * ALU datapath
 * decodes the opcode, drives the three units, selects the result and
 * builds the next carry and zero flags
 */
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
(
	input wire pkg_alu::alu_oper oper,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_lo,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_lo,
	input wire logic [pkg_pflags::proc_flags_width-1:0] proc_flags_in,
	output logic [pkg_alu::alu_inout_width-1:0] next_hi,
	output logic [pkg_alu::alu_inout_width-1:0] next_lo,
	output logic [pkg_pflags::proc_flags_width-1:0] next_flags
);
	import pkg_alu::*;
	import pkg_pflags::*;

	addsub_oper as_oper;
	alu_op_cat op_cat;

	logic carry_in;
	logic [alu_inout_width-1:0] as_hi;
	logic [alu_inout_width-1:0] as_lo;
	logic as_carry;
	logic [alu_inout_width-1:0] bw_hi;
	logic [alu_inout_width-1:0] bw_lo;
	logic [alu_inout_width-1:0] sh_lo;
	logic sh_carry;
	logic sh_keep;

	logic carry_next;
	logic zero_next;
	logic hold_z;

	assign carry_in = proc_flags_in[pf_slot_c];

	// ALU opcode to adder opcode
	always_comb
	begin
		case (oper)
			alu_op_adc: as_oper = addsub_op_adc;
			alu_op_addpb: as_oper = addsub_op_addpb;
			alu_op_addp: as_oper = addsub_op_addp;
			alu_op_addpsnx: as_oper = addsub_op_addpsnx;
			alu_op_sub: as_oper = addsub_op_sub;
			alu_op_sbc: as_oper = addsub_op_sbc;
			alu_op_subpb: as_oper = addsub_op_subpb;
			alu_op_subp: as_oper = addsub_op_subp;
			default: as_oper = addsub_op_add;
		endcase
	end

	adder_subtractor addsub_inst
	(
		.oper(as_oper),
		.a_in_hi(a_in_hi),
		.a_in_lo(a_in_lo),
		.b_in_hi(b_in_hi),
		.b_in_lo(b_in_lo),
		.carry_in(carry_in),
		.out_hi(as_hi),
		.out_lo(as_lo),
		.carry_out(as_carry)
	);

	alu_bitwise bitwise_inst
	(
		.oper(oper),
		.a_in_hi(a_in_hi),
		.a_in_lo(a_in_lo),
		.b_in_lo(b_in_lo),
		.out_hi(bw_hi),
		.out_lo(bw_lo)
	);

	alu_shifter shifter_inst
	(
		.oper(oper),
		.a_in_lo(a_in_lo),
		.b_in_lo(b_in_lo),
		.carry_in(carry_in),
		.out_lo(sh_lo),
		.carry_out(sh_carry),
		.keep_flags(sh_keep)
	);

	// result select and category
	always_comb
	begin
		next_hi = a_in_hi;
		next_lo = a_in_lo;
		carry_next = carry_in;
		hold_z = 1'b0;
		op_cat = alu_op_cat_8;
		case (oper)
			alu_op_add, alu_op_adc, alu_op_sub, alu_op_sbc:
			begin
				next_hi = as_hi;
				next_lo = as_lo;
				carry_next = as_carry;
			end
			alu_op_addpb, alu_op_addp, alu_op_addpsnx, alu_op_subpb, alu_op_subp:
			begin
				{next_hi, next_lo} = {as_hi, as_lo};
				carry_next = as_carry;
				op_cat = alu_op_cat_16;
			end
			// gates and complements keep the carry
			alu_op_and, alu_op_orr, alu_op_xor, alu_op_inv, alu_op_neg:
			begin
				next_lo = bw_lo;
			end
			alu_op_invp, alu_op_negp:
			begin
				{next_hi, next_lo} = {bw_hi, bw_lo};
				op_cat = alu_op_cat_16;
			end
			alu_op_lsl, alu_op_lsr, alu_op_asr, alu_op_rol, alu_op_ror,
				alu_op_rolc, alu_op_rorc:
			begin
				next_lo = sh_lo;
				carry_next = sh_carry;
				hold_z = sh_keep;
			end
			default:
			begin
				// unused encoding, pass a and hold everything
				hold_z = 1'b1;
			end
		endcase
	end

	// zero over the byte or the whole pair
	always_comb
	begin
		if (hold_z)
		begin
			zero_next = proc_flags_in[pf_slot_z];
		end
		else if (op_cat == alu_op_cat_16)
		begin
			zero_next = ({next_hi, next_lo} == '0);
		end
		else
		begin
			zero_next = (next_lo == '0);
		end
	end

	// v and n copied straight through
	always_comb
	begin
		next_flags = proc_flags_in;
		next_flags[pf_slot_c] = carry_next;
		next_flags[pf_slot_z] = zero_next;
	end

endmodule

`default_nettype wire

/* alu_flags_pkg.sv */
/*
 * Processor flag layout
 * width of the flag vector and the bit position of each flag
 */
`default_nettype none

package pkg_pflags;

	localparam int proc_flags_width = 4;

	// carry, 1 also means no borrow on subtract
	localparam int pf_slot_c = 0;
	localparam int pf_slot_z = 1;
	// overflow and negative, never written by the ALU
	localparam int pf_slot_v = 2;
	localparam int pf_slot_n = 3;

endpackage

`default_nettype wire

/* alu_ops_pkg.sv */
/*
 * ALU operation definitions
 * data widths and the opcode, adder opcode and category enums shared by
 * the datapath and its units
 */
`default_nettype none

package pkg_alu;

	// operand byte and register pair widths
	localparam int alu_inout_width = 8;
	localparam int alu_inout_pair_width = 16;

	// width of the instruction's ALU opcode field
	localparam int alu_op_width = 5;

	// ALU opcodes, encodings 23..31 unused
	typedef enum logic [alu_op_width-1:0]
	{
		// arithmetic
		alu_op_add,
		alu_op_adc,
		alu_op_addpb,
		alu_op_addp,
		alu_op_addpsnx,
		alu_op_sub,
		alu_op_sbc,
		alu_op_subpb,
		alu_op_subp,
		// gates and complements
		alu_op_and,
		alu_op_orr,
		alu_op_xor,
		alu_op_inv,
		alu_op_invp,
		alu_op_neg,
		alu_op_negp,
		// 8-bit shifts and rotates
		alu_op_lsl,
		alu_op_lsr,
		alu_op_asr,
		alu_op_rol,
		alu_op_ror,
		alu_op_rolc,
		alu_op_rorc
	} alu_oper;

	// operations of the adder/subtractor unit
	typedef enum logic [3:0]
	{
		addsub_op_add,
		addsub_op_adc,
		addsub_op_addpb,
		addsub_op_addp,
		addsub_op_addpsnx,
		addsub_op_sub,
		addsub_op_sbc,
		addsub_op_subpb,
		addsub_op_subp
	} addsub_oper;

	// zero flag is tested over the byte or over the pair
	typedef enum logic
	{
		alu_op_cat_8,
		alu_op_cat_16
	} alu_op_cat;

endpackage

`default_nettype wire

/* alu_props.sv */
/*
 * ALU properties
 * reset clears the outputs, overflow and negative pass through one cycle late
 */
`timescale 1ns/1ps
`default_nettype none

module alu_props
(
	input wire logic clk,
	input wire logic rst,
	input wire logic [pkg_pflags::proc_flags_width-1:0] proc_flags_in,
	input wire logic [pkg_alu::alu_inout_width-1:0] out_hi,
	input wire logic [pkg_alu::alu_inout_width-1:0] out_lo,
	input wire logic [pkg_pflags::proc_flags_width-1:0] proc_flags_out
);
	import pkg_pflags::*;

	// all outputs zero after a reset edge
	reset_clears: assert property (@(posedge clk)
		rst |=> (out_hi == '0 && out_lo == '0 && proc_flags_out == '0))
		else $error("outputs not zero after reset");

	// v and n never written by the alu
	v_passes: assert property (@(posedge clk)
		!rst |=> proc_flags_out[pf_slot_v] == $past(proc_flags_in[pf_slot_v]))
		else $error("overflow flag not passed through");

	n_passes: assert property (@(posedge clk)
		!rst |=> proc_flags_out[pf_slot_n] == $past(proc_flags_in[pf_slot_n]))
		else $error("negative flag not passed through");

endmodule

bind alu alu_props alu_props_inst
(
	.clk(clk),
	.rst(rst),
	.proc_flags_in(proc_flags_in),
	.out_hi(out_hi),
	.out_lo(out_lo),
	.proc_flags_out(proc_flags_out)
);

`default_nettype wire

/* alu_shifter.sv */
/*
 * Byte shifter
 * logical and arithmetic shifts with carry capture, rotates by the
 * amount mod 8, and one-bit rotates through carry
 */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter
(
	input wire pkg_alu::alu_oper oper,
	input wire logic [pkg_alu::alu_inout_width-1:0] a_in_lo,
	input wire logic [pkg_alu::alu_inout_width-1:0] b_in_lo,
	input wire logic carry_in,
	output logic [pkg_alu::alu_inout_width-1:0] out_lo,
	output logic carry_out,
	output logic keep_flags
);
	import pkg_alu::*;

	localparam int rot_amt_width = $clog2(alu_inout_width);

	logic amt_zero;
	// rotate amount, b mod 8
	logic [rot_amt_width-1:0] rot_amt;
	// two copies of a, a rotate is a window into it
	logic [2*alu_inout_width-1:0] rot_dbl;

	assign amt_zero = (b_in_lo == '0);
	assign rot_amt = b_in_lo[rot_amt_width-1:0];
	assign rot_dbl = {a_in_lo, a_in_lo};

	always_comb
	begin
		out_lo = a_in_lo;
		carry_out = carry_in;
		keep_flags = 1'b0;
		case (oper)
			alu_op_lsl:
			begin
				// carry gets the last bit out the top
				// 9 or more leaves 0 and a clear carry
				if (!amt_zero)
				begin
					{carry_out, out_lo} = {1'b0, a_in_lo} << b_in_lo;
				end
			end
			alu_op_lsr:
			begin
				// carry gets the last bit out the bottom
				if (!amt_zero)
				begin
					{out_lo, carry_out} = {a_in_lo, 1'b0} >> b_in_lo;
				end
			end
			alu_op_asr:
			begin
				// sign fill, so large amounts saturate to 0 or all ones
				if (!amt_zero)
				begin
					{out_lo, carry_out} = $signed({a_in_lo, 1'b0}) >>> b_in_lo;
				end
			end
			alu_op_rol:
			begin
				// carry kept
				if (!amt_zero)
				begin
					out_lo = rot_dbl[(alu_inout_width - rot_amt) +: alu_inout_width];
				end
			end
			alu_op_ror:
			begin
				if (!amt_zero)
				begin
					out_lo = rot_dbl[rot_amt +: alu_inout_width];
				end
			end
			alu_op_rolc:
			begin
				// 9-bit {c, a} rotated left by one
				{carry_out, out_lo} = {a_in_lo, carry_in};
			end
			alu_op_rorc:
			begin
				{out_lo, carry_out} = {carry_in, a_in_lo};
			end
			default:
			begin
				out_lo = a_in_lo;
			end
		endcase

		// zero amount passes a and holds carry and zero
		if (amt_zero && (oper == alu_op_lsl || oper == alu_op_lsr || oper == alu_op_asr
			|| oper == alu_op_rol || oper == alu_op_ror))
		begin
			keep_flags = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
alu_ops_pkg.sv
alu_flags_pkg.sv
adder_subtractor.sv
alu_bitwise.sv
alu_shifter.sv
alu_datapath.sv
alu.sv
alu_props.sv
tb_alu.sv

/* tb_alu.sv */
/*
 * ALU testbench
 * runs a table of operations back to back through the registered ALU and
 * checks each result pair and flag vector one cycle later
 */
`timescale 1ns/1ps
`default_nettype none

module tb_alu;
	import pkg_alu::*;
	import pkg_pflags::*;

	// polling steps of 1 ns before a missing edge counts as a timeout
	localparam int poll_limit = 100;

	logic clk;
	logic rst;
	alu_oper oper;
	logic [alu_inout_width-1:0] a_in_hi;
	logic [alu_inout_width-1:0] a_in_lo;
	logic [alu_inout_width-1:0] b_in_hi;
	logic [alu_inout_width-1:0] b_in_lo;
	logic [proc_flags_width-1:0] proc_flags_in;
	logic [alu_inout_width-1:0] out_hi;
	logic [alu_inout_width-1:0] out_lo;
	logic [proc_flags_width-1:0] proc_flags_out;

	// table columns, one entry per row
	string row_name[$];
	logic [alu_op_width-1:0] row_op[$];
	logic [alu_inout_pair_width-1:0] row_a[$];
	logic [alu_inout_pair_width-1:0] row_b[$];
	logic [proc_flags_width-1:0] row_fin[$];
	logic [alu_inout_pair_width-1:0] row_exp[$];
	logic [proc_flags_width-1:0] row_eflags[$];

	int errors;
	int tests_run;
	int tests_failed;
	bit row_bad;
	bit timed_out;

	alu alu_inst
	(
		.clk(clk),
		.rst(rst),
		.oper(oper),
		.a_in_hi(a_in_hi),
		.a_in_lo(a_in_lo),
		.b_in_hi(b_in_hi),
		.b_in_lo(b_in_lo),
		.proc_flags_in(proc_flags_in),
		.out_hi(out_hi),
		.out_lo(out_lo),
		.proc_flags_out(proc_flags_out)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// flags column is {n, v, z, c}
	task automatic add_row(input string name, input logic [4:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic [3:0] fin, input logic [15:0] exp,
		input logic [3:0] eflags);
		begin
			row_name.push_back(name);
			row_op.push_back(op);
			row_a.push_back(a);
			row_b.push_back(b);
			row_fin.push_back(fin);
			row_exp.push_back(exp);
			row_eflags.push_back(eflags);
		end
	endtask

	task automatic build_table;
		begin
			// byte arithmetic, high byte echoes a
			add_row("add carry", alu_op_add, 16'h12f0, 16'h0020, 4'b0000, 16'h1210, 4'b0001);
			add_row("add zero", alu_op_add, 16'ha580, 16'h0080, 4'b0000, 16'ha500, 4'b0011);
			add_row("adc c in", alu_op_adc, 16'h0010, 16'h0020, 4'b0001, 16'h0031, 4'b0000);
			add_row("adc wrap", alu_op_adc, 16'h00ff, 16'h0000, 4'b0001, 16'h0000, 4'b0011);
			add_row("sub no borrow", alu_op_sub, 16'h7730, 16'h0010, 4'b0000, 16'h7720, 4'b0001);
			add_row("sub borrow", alu_op_sub, 16'h7710, 16'h0030, 4'b1100, 16'h77e0, 4'b1100);
			add_row("sbc c clear", alu_op_sbc, 16'h0030, 16'h0010, 4'b0000, 16'h001f, 4'b0001);
			add_row("sbc zero", alu_op_sbc, 16'h0010, 16'h0010, 4'b0001, 16'h0000, 4'b0011);
			// pair arithmetic, zero over all 16 bits
			add_row("addp", alu_op_addp, 16'h12f0, 16'h0120, 4'b0000, 16'h1410, 4'b0000);
			add_row("addp zero", alu_op_addp, 16'hff00, 16'h0100, 4'b0000, 16'h0000, 4'b0011);
			add_row("addpb lo zero", alu_op_addpb, 16'h1280, 16'hee80, 4'b0010, 16'h1300, 4'b0000);
			add_row("addpb", alu_op_addpb, 16'h12f0, 16'hff20, 4'b0000, 16'h1310, 4'b0000);
			add_row("addpsnx neg", alu_op_addpsnx, 16'h1234, 16'h00fe, 4'b0000, 16'h1232, 4'b0001);
			add_row("addpsnx pos", alu_op_addpsnx, 16'h1234, 16'haa10, 4'b0000, 16'h1244, 4'b0000);
			add_row("subp zero", alu_op_subp, 16'h1234, 16'h1234, 4'b0000, 16'h0000, 4'b0011);
			add_row("subp borrow", alu_op_subp, 16'h1000, 16'h2000, 4'b0000, 16'hf000, 4'b0000);
			add_row("subpb", alu_op_subpb, 16'h1200, 16'h5501, 4'b0000, 16'h11ff, 4'b0001);
			// gates and complements, carry v n held
			add_row("and", alu_op_and, 16'h9af0, 16'h003c, 4'b1101, 16'h9a30, 4'b1101);
			add_row("orr zero", alu_op_orr, 16'h7700, 16'h0000, 4'b0001, 16'h7700, 4'b0011);
			add_row("xor zero", alu_op_xor, 16'h00aa, 16'h00aa, 4'b0100, 16'h0000, 4'b0110);
			add_row("inv", alu_op_inv, 16'h340f, 16'h0000, 4'b1001, 16'h34f0, 4'b1001);
			add_row("invp zero", alu_op_invp, 16'hffff, 16'h0000, 4'b0001, 16'h0000, 4'b0011);
			add_row("neg", alu_op_neg, 16'h5601, 16'h0000, 4'b0010, 16'h56ff, 4'b0000);
			add_row("negp", alu_op_negp, 16'h0001, 16'h0000, 4'b1000, 16'hffff, 4'b1000);
			// shifts, carry is the last bit out
			add_row("lsl 1", alu_op_lsl, 16'h0081, 16'h0001, 4'b0000, 16'h0002, 4'b0001);
			add_row("lsl 8", alu_op_lsl, 16'h0081, 16'h0008, 4'b0000, 16'h0000, 4'b0011);
			add_row("lsl 9", alu_op_lsl, 16'h0081, 16'h0009, 4'b0001, 16'h0000, 4'b0010);
			add_row("lsr 1", alu_op_lsr, 16'h0081, 16'h0001, 4'b0000, 16'h0040, 4'b0001);
			add_row("lsr 10", alu_op_lsr, 16'h0081, 16'h000a, 4'b0001, 16'h0000, 4'b0010);
			add_row("asr 1", alu_op_asr, 16'h0081, 16'h0001, 4'b0000, 16'h00c0, 4'b0001);
			add_row("asr 9", alu_op_asr, 16'h007f, 16'h0009, 4'b0001, 16'h0000, 4'b0010);
			// rotates by amount mod 8 keep carry
			add_row("rol 10", alu_op_rol, 16'h0081, 16'h000a, 4'b0001, 16'h0006, 4'b0001);
			add_row("ror 11", alu_op_ror, 16'h0081, 16'h000b, 4'b0000, 16'h0030, 4'b0000);
			add_row("rolc c set", alu_op_rolc, 16'h0080, 16'h0000, 4'b0001, 16'h0001, 4'b0001);
			add_row("rolc c clear", alu_op_rolc, 16'h0080, 16'h0000, 4'b0000, 16'h0000, 4'b0011);
			add_row("rorc c set", alu_op_rorc, 16'h0001, 16'h0000, 4'b0001, 16'h0080, 4'b0001);
			add_row("rorc c clear", alu_op_rorc, 16'h0001, 16'h0000, 4'b0000, 16'h0000, 4'b0011);
			// zero amount and unused opcode hold the flags
			add_row("lsl 0", alu_op_lsl, 16'h0000, 16'h0000, 4'b0001, 16'h0000, 4'b0001);
			add_row("ror 0", alu_op_ror, 16'h005a, 16'h0000, 4'b0010, 16'h005a, 4'b0010);
			add_row("unused op", 5'd27, 16'h115a, 16'h3344, 4'b1011, 16'h115a, 4'b1011);
		end
	endtask

	// polls at half-ns offsets so no sample lands on a clock edge;
	// returns 1 ns after the rising edge
	task automatic next_cycle;
		int n;
		begin
			n = 0;
			#0.5;
			while (clk === 1'b1 && n < poll_limit)
			begin
				#1;
				n++;
			end
			while (clk !== 1'b1 && n < poll_limit)
			begin
				#1;
				n++;
			end
			if (clk !== 1'b1)
			begin
				timed_out = 1'b1;
			end
			else
			begin
				#0.5;
			end
		end
	endtask

	task automatic check_value(input string sig, input logic [15:0] actual,
		input logic [15:0] expected);
		begin
			if (actual !== expected)
			begin
				$display("ERROR at %0t ns: %s is %h, expected %h", $time, sig, actual, expected);
				errors++;
				row_bad = 1'b1;
			end
		end
	endtask

	task automatic report_test(input string name);
		begin
			tests_run++;
			if (row_bad)
			begin
				tests_failed++;
			end
			$display("%-16s %s", name, row_bad ? "mismatch" : "ok");
		end
	endtask

	task automatic apply_row(input int i);
		begin
			oper = alu_oper'(row_op[i]);
			{a_in_hi, a_in_lo} = row_a[i];
			{b_in_hi, b_in_lo} = row_b[i];
			proc_flags_in = row_fin[i];
		end
	endtask

	task automatic check_row(input int i);
		begin
			row_bad = 1'b0;
			check_value("out_hi", {8'h00, out_hi}, {8'h00, row_exp[i][15:8]});
			check_value("out_lo", {8'h00, out_lo}, {8'h00, row_exp[i][7:0]});
			check_value("proc_flags_out", {12'h000, proc_flags_out}, {12'h000, row_eflags[i]});
			report_test(row_name[i]);
		end
	endtask

	initial
	begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		// operands in reset give a nonzero result and flags, so reset must clear them
		oper = alu_op_add;
		a_in_hi = 8'h5a;
		a_in_lo = 8'ha5;
		b_in_hi = '0;
		b_in_lo = '0;
		proc_flags_in = 4'b1100;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		row_bad = 1'b0;
		timed_out = 1'b0;
		build_table();

		// reset held through two edges
		next_cycle();
		if (!timed_out)
		begin
			next_cycle();
		end
		if (!timed_out)
		begin
			row_bad = 1'b0;
			check_value("out_hi", {8'h00, out_hi}, 16'h0000);
			check_value("out_lo", {8'h00, out_lo}, 16'h0000);
			check_value("proc_flags_out", {12'h000, proc_flags_out}, 16'h0000);
			report_test("reset");
			rst = 1'b0;
			apply_row(0);
		end

		// one row per cycle, each result checked one edge later
		for (i = 0; i < row_name.size() && !timed_out; i++)
		begin
			next_cycle();
			if (!timed_out)
			begin
				check_row(i);
				if (i + 1 < row_name.size())
				begin
					apply_row(i + 1);
				end
			end
		end

		if (timed_out)
		begin
			$display("timeout: no rising clk edge within %0d ns", poll_limit);
		end
		$display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && !timed_out)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
